// ==== Makefile ====
TOOL   = verilator
FLAGS  = --binary --timing -j 0
TOP    = dpu_tb
FLIST  = build.f
OBJDIR = obj_dir
BIN    = $(OBJDIR)/V$(TOP)
LOG    = sim.log
SRCS   = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bench/dpu_tb.sv ====
`timescale 1ns/1ps

module dpu_tb;

   localparam int CLK_PERIOD  = 40;
   localparam int DRIVE_DLY   = 1;
   localparam int RESET_CYC   = 10;
   localparam int N_OPS       = 34;     // 18 vv, 6 scalar, 6 imm, 2 reserved opcodes, 2 back to back
   localparam int TIMEOUT_CYC = N_OPS * 40 + RESET_CYC;
   localparam int ACK_LIMIT   = 8;
   localparam int POLL_LIMIT  = 4 * dpu_cfg_pkg::PIPE_DEPTH;
   localparam int AW          = dpu_cfg_pkg::ADR_W;

   // Kinds of check request
   localparam int KIND_RES    = 0;
   localparam int KIND_ZERO   = 1;
   localparam int KIND_STATUS = 2;

   logic          clk;
   logic          rstn;
   logic [AW-1:0] wb_adr;
   logic [31:0]   wb_dat_w;
   logic [31:0]   wb_dat_r;
   logic          wb_we;
   logic          wb_cyc;
   logic          wb_stb;
   logic          wb_ack;

   logic [31:0] vs1_v [4];
   logic [31:0] vs2_v [4];
   logic [31:0] scalar_v;
   logic [31:0] rng;
   int          err_cnt;
   int          cycle_cnt;

   // Handed from the sequence to the compare process
   string       chk_name;
   int          chk_kind;
   logic [31:0] chk_ctrl;
   logic [31:0] chk_status_exp;
   logic        chk_stuck;
   logic [31:0] got_w [4];
   int          req_cnt;
   int          done_cnt;
   int          test_cnt;
   int          fail_cnt;

   string op_name [6] = '{"add", "sub", "and", "or", "xor", "maxu"};
   logic [dpu_op_pkg::OPMODE_W-1:0] op_code [6] = '{dpu_op_pkg::OP_ADD, dpu_op_pkg::OP_SUB,
      dpu_op_pkg::OP_AND, dpu_op_pkg::OP_OR, dpu_op_pkg::OP_XOR, dpu_op_pkg::OP_MAXU};
   logic [dpu_op_pkg::SEW_W-1:0] sew_code [3] = '{dpu_op_pkg::SEW_8, dpu_op_pkg::SEW_16,
      dpu_op_pkg::SEW_32};

   dpu_top uut
     (
      .clk_i(clk), .rstn_i(rstn),
      .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_we_i(wb_we),
      .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
      .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack)
      );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYC)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("sim failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus and reference

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] make_ctrl(input logic [dpu_op_pkg::OPMODE_W-1:0] op,
                                             input logic [dpu_op_pkg::SEW_W-1:0] sew,
                                             input logic [dpu_op_pkg::OP2SEL_W-1:0] sel,
                                             input logic [dpu_op_pkg::IMM_W-1:0] imm);
      logic [31:0] c;
      c = '0;
      c[dpu_op_pkg::CTRL_OPMODE_LSB +: dpu_op_pkg::OPMODE_W] = op;
      c[dpu_op_pkg::CTRL_SEW_LSB +: dpu_op_pkg::SEW_W]       = sew;
      c[dpu_op_pkg::CTRL_OP2SEL_LSB +: dpu_op_pkg::OP2SEL_W] = sel;
      c[dpu_op_pkg::CTRL_IMM_LSB +: dpu_op_pkg::IMM_W]       = imm;
      return c;
   endfunction

   // Expected lane word built one element at a time
   function automatic logic [31:0] expected_lane(input int lane, input logic [31:0] ctrl);
      logic [dpu_op_pkg::OPMODE_W-1:0] op;
      logic [dpu_op_pkg::SEW_W-1:0]    sew;
      logic [dpu_op_pkg::OP2SEL_W-1:0] sel;
      logic [dpu_op_pkg::IMM_W-1:0]    imm;
      logic [31:0] mask;
      logic [31:0] imm_ext;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      logic [31:0] result;
      int          ew;
      op  = ctrl[dpu_op_pkg::CTRL_OPMODE_LSB +: dpu_op_pkg::OPMODE_W];
      sew = ctrl[dpu_op_pkg::CTRL_SEW_LSB +: dpu_op_pkg::SEW_W];
      sel = ctrl[dpu_op_pkg::CTRL_OP2SEL_LSB +: dpu_op_pkg::OP2SEL_W];
      imm = ctrl[dpu_op_pkg::CTRL_IMM_LSB +: dpu_op_pkg::IMM_W];
      result = '0;
      case (sew)
         dpu_op_pkg::SEW_8:  ew = 8;
         dpu_op_pkg::SEW_16: ew = 16;
         dpu_op_pkg::SEW_32: ew = 32;
         default:            ew = 0;    // Reserved width gives zero
      endcase
      if (ew != 0)
      begin
         mask    = (ew == 32) ? 32'hffff_ffff : ((32'd1 << ew) - 32'd1);
         imm_ext = {{(32 - dpu_op_pkg::IMM_W){imm[dpu_op_pkg::IMM_W-1]}}, imm} & mask;
         for (int k = 0; k < 32 / ew; k++)
         begin
            a = (vs1_v[lane] >> (k * ew)) & mask;
            if (sel == dpu_op_pkg::OP2_SCALAR)
               b = scalar_v & mask;
            else if (sel == dpu_op_pkg::OP2_IMM)
               b = imm_ext;
            else
               b = (vs2_v[lane] >> (k * ew)) & mask;
            case (op)
               dpu_op_pkg::OP_ADD:  r = a + b;
               dpu_op_pkg::OP_SUB:  r = a - b;
               dpu_op_pkg::OP_AND:  r = a & b;
               dpu_op_pkg::OP_OR:   r = a | b;
               dpu_op_pkg::OP_XOR:  r = a ^ b;
               dpu_op_pkg::OP_MAXU: r = (a > b) ? a : b;
               default:             r = '0;
            endcase
            result = result | ((r & mask) << (k * ew));
         end
      end
      return result;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Wishbone master

   task automatic bus_cycle(input logic we, input logic [AW-1:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
      int waits;
      @(posedge clk);
      #DRIVE_DLY;
      wb_adr   = adr;
      wb_dat_w = wdat;
      wb_we    = we;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      waits    = 0;
      do
      begin
         @(posedge clk);
         #DRIVE_DLY;
         waits++;
      end
      while (!wb_ack && waits < ACK_LIMIT);
      rdat = wb_dat_r;
      if (!wb_ack)
      begin
         $display("No ack from the DUT for the access at address %0d", adr);
         err_cnt++;
         rdat = '0;
      end
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_write(input logic [AW-1:0] adr, input logic [31:0] dat);
      logic [31:0] unused;
      bus_cycle(1'b1, adr, dat, unused);
   endtask

   task automatic wb_read(input logic [AW-1:0] adr, output logic [31:0] dat);
      bus_cycle(1'b0, adr, '0, dat);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence helpers

   task automatic fill_random();
      for (int l = 0; l < 4; l++)
      begin
         rng = xorshift32(rng);
         vs1_v[l] = rng;
         rng = xorshift32(rng);
         vs2_v[l] = rng;
      end
      rng = xorshift32(rng);
      scalar_v = rng;
      // Lanes 2 and 3 wrap every element
      vs1_v[2] = 32'h0000_0000;
      vs2_v[2] = 32'h0101_0101;
      vs1_v[3] = 32'hffff_ffff;
      vs2_v[3] = 32'h0101_0101;
   endtask

   task automatic load_operands();
      for (int l = 0; l < 4; l++)
      begin
         wb_write(AW'(int'(dpu_cfg_pkg::ADR_VS1_BASE) + l), vs1_v[l]);
         wb_write(AW'(int'(dpu_cfg_pkg::ADR_VS2_BASE) + l), vs2_v[l]);
      end
      wb_write(dpu_cfg_pkg::ADR_SCALAR, scalar_v);
   endtask

   task automatic send_check();
      req_cnt++;
      wait (done_cnt == req_cnt);
   endtask

   // Poll busy, then fetch the four result words
   task automatic read_back(input string name, input logic [31:0] ctrl, input int kind);
      logic [31:0] rd;
      int          polls;
      rd    = 32'd1;
      polls = 0;
      while (rd[0] && polls < POLL_LIMIT)
      begin
         wb_read(dpu_cfg_pkg::ADR_STATUS, rd);
         polls++;
      end
      chk_stuck = rd[0];
      for (int l = 0; l < 4; l++)
      begin
         got_w[l] = '0;
         if (!chk_stuck)
            wb_read(AW'(int'(dpu_cfg_pkg::ADR_RES_BASE) + l), got_w[l]);
      end
      chk_name = name;
      chk_ctrl = ctrl;
      chk_kind = kind;
      send_check();
   endtask

   task automatic check_status(input string name, input logic [31:0] exp);
      wb_read(dpu_cfg_pkg::ADR_STATUS, got_w[0]);
      chk_name       = name;
      chk_kind       = KIND_STATUS;
      chk_status_exp = exp;
      chk_stuck      = 1'b0;
      send_check();
   endtask

   task automatic run_op(input string name, input logic [31:0] ctrl);
      load_operands();
      wb_write(dpu_cfg_pkg::ADR_CTRL, ctrl);
      read_back(name, ctrl, KIND_RES);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Compare process

   initial
   begin
      logic [31:0] exp;
      logic        ok;
      done_cnt = 0;
      test_cnt = 0;
      fail_cnt = 0;
      forever
      begin
         wait (req_cnt != done_cnt);
         ok = 1'b1;
         if (chk_kind == KIND_STATUS)
         begin
            if (got_w[0] !== chk_status_exp)
            begin
               $display("MISMATCH %s status: expected 0x%08h, got 0x%08h",
                        chk_name, chk_status_exp, got_w[0]);
               ok = 1'b0;
            end
         end
         else if (chk_stuck)
         begin
            $display("%s: busy was still set after %0d status reads", chk_name, POLL_LIMIT);
            ok = 1'b0;
         end
         else
         begin
            for (int l = 0; l < 4; l++)
            begin
               exp = (chk_kind == KIND_ZERO) ? 32'd0 : expected_lane(l, chk_ctrl);
               if (got_w[l] !== exp)
               begin
                  $display("MISMATCH %s res_lane%0d: expected 0x%08h, got 0x%08h",
                           chk_name, l, exp, got_w[l]);
                  ok = 1'b0;
               end
            end
         end
         test_cnt++;
         if (ok)
            $display("PASS  %s", chk_name);
         else
         begin
            fail_cnt++;
            $display("FAIL  %s", chk_name);
         end
         done_cnt++;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence

   initial
   begin
      logic [31:0] c1;
      logic [31:0] c2;
      rstn     = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      wb_we    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      err_cnt  = 0;
      req_cnt  = 0;
      rng      = 32'ha379;
      repeat (RESET_CYC) @(posedge clk);
      #DRIVE_DLY;
      rstn = 1'b1;

      check_status("reset status", 32'd0);
      read_back("reset results", '0, KIND_ZERO);

      for (int o = 0; o < 6; o++)
      begin
         for (int s = 0; s < 3; s++)
         begin
            fill_random();
            run_op($sformatf("vv %s sew%0d", op_name[o], 8 << s),
                   make_ctrl(op_code[o], sew_code[s], dpu_op_pkg::OP2_VEC, '0));
         end
      end

      for (int s = 0; s < 3; s++)
      begin
         fill_random();
         run_op($sformatf("scalar add sew%0d", 8 << s),
                make_ctrl(dpu_op_pkg::OP_ADD, sew_code[s], dpu_op_pkg::OP2_SCALAR, '0));
         run_op($sformatf("scalar maxu sew%0d", 8 << s),
                make_ctrl(dpu_op_pkg::OP_MAXU, sew_code[s], dpu_op_pkg::OP2_SCALAR, '0));
      end

      // -13 and +11
      for (int s = 0; s < 3; s++)
      begin
         fill_random();
         run_op($sformatf("imm negative sew%0d", 8 << s),
                make_ctrl(dpu_op_pkg::OP_ADD, sew_code[s], dpu_op_pkg::OP2_IMM, 5'h13));
         run_op($sformatf("imm positive sew%0d", 8 << s),
                make_ctrl(dpu_op_pkg::OP_ADD, sew_code[s], dpu_op_pkg::OP2_IMM, 5'h0b));
      end

      fill_random();
      load_operands();
      c1 = make_ctrl(3'd6, dpu_op_pkg::SEW_32, dpu_op_pkg::OP2_VEC, '0);
      wb_write(dpu_cfg_pkg::ADR_CTRL, c1);
      check_status("busy after launch", 32'd1);
      read_back("opcode 6 result", c1, KIND_RES);
      check_status("idle after finish", 32'd0);
      run_op("opcode 7 result", make_ctrl(3'd7, dpu_op_pkg::SEW_8, dpu_op_pkg::OP2_VEC, '0));

      // Second launch while the first is in flight
      fill_random();
      load_operands();
      c1 = make_ctrl(dpu_op_pkg::OP_SUB, dpu_op_pkg::SEW_16, dpu_op_pkg::OP2_VEC, '0);
      c2 = make_ctrl(dpu_op_pkg::OP_XOR, dpu_op_pkg::SEW_8, dpu_op_pkg::OP2_SCALAR, '0);
      wb_write(dpu_cfg_pkg::ADR_CTRL, c1);
      wb_write(dpu_cfg_pkg::ADR_CTRL, c2);
      read_back("back to back", c2, KIND_RES);

      $display("Tests run %0d, failed %0d, bus errors %0d", test_cnt, fail_cnt, err_cnt);
      if (fail_cnt == 0 && err_cnt == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

// ==== build.f ====
hdl/dpu_cfg_pkg.sv
hdl/dpu_op_pkg.sv
hdl/dpu_wb_regs.sv
hdl/dpu_operand_stage.sv
hdl/dpu_alu_stage.sv
hdl/dpu_result_stage.sv
hdl/dpu_top.sv
bench/dpu_tb.sv

// ==== hdl/dpu_alu_stage.sv ====
`timescale 1ns/1ps

module dpu_alu_stage
  (
   input  logic                                             clk_i,
   input  logic                                             rstn_i,

   input  logic                                             op_vld_i,
   input  logic [dpu_op_pkg::OPMODE_W-1:0]                  opmode_i,
   input  logic [dpu_op_pkg::SEW_W-1:0]                     sew_i,
   input  logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] opa_i,
   input  logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] opb_i,

   output logic                                             res_vld_o,
   output logic [dpu_op_pkg::SEW_W-1:0]                     sew_o,
   output logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] res_o
  );

   logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] res;

   // Elements come in zero-extended
   function automatic logic [31:0] elem_op(input logic [dpu_op_pkg::OPMODE_W-1:0] op,
                                           input logic [31:0] a,
                                           input logic [31:0] b);
      case (op)
         dpu_op_pkg::OP_ADD:  elem_op = a + b;
         dpu_op_pkg::OP_SUB:  elem_op = a - b;
         dpu_op_pkg::OP_AND:  elem_op = a & b;
         dpu_op_pkg::OP_OR:   elem_op = a | b;
         dpu_op_pkg::OP_XOR:  elem_op = a ^ b;
         dpu_op_pkg::OP_MAXU: elem_op = (a > b) ? a : b;
         default:             elem_op = '0;
      endcase
   endfunction

   always_comb
   begin
      dpu_op_pkg::lane_word_u a;
      dpu_op_pkg::lane_word_u b;
      dpu_op_pkg::lane_word_u ea;
      dpu_op_pkg::lane_word_u eb;
      dpu_op_pkg::lane_word_u er;
      dpu_op_pkg::lane_word_u r;
      for (int l = 0; l < dpu_cfg_pkg::LANE_NUM; l++)
      begin
         a.w  = opa_i[l*dpu_cfg_pkg::LANE_W +: dpu_cfg_pkg::LANE_W];
         b.w  = opb_i[l*dpu_cfg_pkg::LANE_W +: dpu_cfg_pkg::LANE_W];
         ea.w = '0;
         eb.w = '0;
         er.w = '0;
         r.w  = '0;
         case (sew_i)
            dpu_op_pkg::SEW_8:
            begin
               for (int k = 0; k < 4; k++)
               begin
                  ea.b[0] = a.b[k];
                  eb.b[0] = b.b[k];
                  er.w    = elem_op(opmode_i, ea.w, eb.w);
                  r.b[k]  = er.b[0];   // Carry out dropped
               end
            end
            dpu_op_pkg::SEW_16:
            begin
               for (int k = 0; k < 2; k++)
               begin
                  ea.h[0] = a.h[k];
                  eb.h[0] = b.h[k];
                  er.w    = elem_op(opmode_i, ea.w, eb.w);
                  r.h[k]  = er.h[0];
               end
            end
            dpu_op_pkg::SEW_32: r.w = elem_op(opmode_i, a.w, b.w);
            default:            r.w = '0;
         endcase
         res[l*dpu_cfg_pkg::LANE_W +: dpu_cfg_pkg::LANE_W] = r.w;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rstn_i)
      begin
         res_vld_o <= 1'b0;
         sew_o     <= '0;
      end
      else
      begin
         res_vld_o <= op_vld_i;
         sew_o     <= sew_i;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rstn_i)
         res_o <= '0;
      else
         res_o <= res;
   end

endmodule

// ==== hdl/dpu_cfg_pkg.sv ====
package dpu_cfg_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Datapath sizes

   localparam int LANE_NUM   = 4;
   localparam int LANE_W     = 32;      // One lane word
   localparam int PIPE_DEPTH = 3;       // Operands, ALU, results

   ////////////////////////////////////////////////////////////////////////////
   // Wishbone word address map

   localparam int ADR_W = 4;

   // Lanes 0 to 3 follow each base
   localparam logic [ADR_W-1:0] ADR_VS1_BASE = 4'd0;
   localparam logic [ADR_W-1:0] ADR_VS2_BASE = 4'd4;

   localparam logic [ADR_W-1:0] ADR_SCALAR   = 4'd8;
   localparam logic [ADR_W-1:0] ADR_CTRL     = 4'd9;    // Write starts an operation
   localparam logic [ADR_W-1:0] ADR_STATUS   = 4'd10;   // Bit 0 busy, read only

   // Read only result words
   localparam logic [ADR_W-1:0] ADR_RES_BASE = 4'd12;

endpackage

// ==== hdl/dpu_op_pkg.sv ====
package dpu_op_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Operation codes

   localparam int OPMODE_W = 3;

   localparam logic [OPMODE_W-1:0] OP_ADD  = 3'd0;
   localparam logic [OPMODE_W-1:0] OP_SUB  = 3'd1;
   localparam logic [OPMODE_W-1:0] OP_AND  = 3'd2;
   localparam logic [OPMODE_W-1:0] OP_OR   = 3'd3;
   localparam logic [OPMODE_W-1:0] OP_XOR  = 3'd4;
   localparam logic [OPMODE_W-1:0] OP_MAXU = 3'd5;  // Codes 6 and 7 give zero

   // Element width
   localparam int SEW_W = 2;

   localparam logic [SEW_W-1:0] SEW_8  = 2'd0;
   localparam logic [SEW_W-1:0] SEW_16 = 2'd1;
   localparam logic [SEW_W-1:0] SEW_32 = 2'd2;

   // Operand 2 source
   localparam int OP2SEL_W = 2;

   localparam logic [OP2SEL_W-1:0] OP2_VEC    = 2'd0;   // Code 3 acts the same
   localparam logic [OP2SEL_W-1:0] OP2_SCALAR = 2'd1;
   localparam logic [OP2SEL_W-1:0] OP2_IMM    = 2'd2;

   localparam int IMM_W = 5;

   // Control word field positions
   localparam int CTRL_OPMODE_LSB = 0;
   localparam int CTRL_SEW_LSB    = 4;
   localparam int CTRL_OP2SEL_LSB = 8;
   localparam int CTRL_IMM_LSB    = 16;

   // One lane word seen as word, halfwords or bytes
   typedef union packed {
      logic [31:0]      w;
      logic [1:0][15:0] h;
      logic [3:0][7:0]  b;
   } lane_word_u;

endpackage

// ==== hdl/dpu_operand_stage.sv ====
`timescale 1ns/1ps

module dpu_operand_stage
  (
   input  logic                                             clk_i,
   input  logic                                             rstn_i,

   input  logic                                             launch_i,
   input  logic [31:0]                                      ctrl_i,
   input  logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] vs1_i,
   input  logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] vs2_i,
   input  logic [31:0]                                      scalar_i,

   output logic                                             op_vld_o,
   output logic [dpu_op_pkg::OPMODE_W-1:0]                  opmode_o,
   output logic [dpu_op_pkg::SEW_W-1:0]                     sew_o,
   output logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] opa_o,
   output logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] opb_o
  );

   logic [dpu_op_pkg::OPMODE_W-1:0] opmode;
   logic [dpu_op_pkg::SEW_W-1:0]    sew;
   logic [dpu_op_pkg::OP2SEL_W-1:0] op2sel;
   logic [dpu_op_pkg::IMM_W-1:0]    imm;
   dpu_op_pkg::lane_word_u          scal_src;
   dpu_op_pkg::lane_word_u          imm_src;
   dpu_op_pkg::lane_word_u          scal_rep;
   dpu_op_pkg::lane_word_u          imm_rep;
   logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] opb;

   assign opmode = ctrl_i[dpu_op_pkg::CTRL_OPMODE_LSB +: dpu_op_pkg::OPMODE_W];
   assign sew    = ctrl_i[dpu_op_pkg::CTRL_SEW_LSB +: dpu_op_pkg::SEW_W];
   assign op2sel = ctrl_i[dpu_op_pkg::CTRL_OP2SEL_LSB +: dpu_op_pkg::OP2SEL_W];
   assign imm    = ctrl_i[dpu_op_pkg::CTRL_IMM_LSB +: dpu_op_pkg::IMM_W];

   assign scal_src.w = scalar_i;
   assign imm_src.w  = {{(32 - dpu_op_pkg::IMM_W){imm[dpu_op_pkg::IMM_W-1]}}, imm};

   // Low element repeated across the word
   always_comb
   begin
      scal_rep.w = scal_src.w;
      imm_rep.w  = imm_src.w;
      case (sew)
         dpu_op_pkg::SEW_8:
         begin
            for (int k = 0; k < 4; k++)
            begin
               scal_rep.b[k] = scal_src.b[0];
               imm_rep.b[k]  = imm_src.b[0];
            end
         end
         dpu_op_pkg::SEW_16:
         begin
            for (int k = 0; k < 2; k++)
            begin
               scal_rep.h[k] = scal_src.h[0];
               imm_rep.h[k]  = imm_src.h[0];
            end
         end
         default: ;   // Whole word already
      endcase
   end

   always_comb
   begin
      for (int l = 0; l < dpu_cfg_pkg::LANE_NUM; l++)
      begin
         case (op2sel)
            dpu_op_pkg::OP2_SCALAR: opb[l*dpu_cfg_pkg::LANE_W +: dpu_cfg_pkg::LANE_W] = scal_rep.w;
            dpu_op_pkg::OP2_IMM:    opb[l*dpu_cfg_pkg::LANE_W +: dpu_cfg_pkg::LANE_W] = imm_rep.w;
            default: opb[l*dpu_cfg_pkg::LANE_W +: dpu_cfg_pkg::LANE_W] =
                        vs2_i[l*dpu_cfg_pkg::LANE_W +: dpu_cfg_pkg::LANE_W];
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rstn_i)
      begin
         op_vld_o <= 1'b0;
         opmode_o <= '0;
         sew_o    <= '0;
      end
      else
      begin
         op_vld_o <= launch_i;
         if (launch_i)
         begin
            opmode_o <= opmode;
            sew_o    <= sew;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rstn_i)
      begin
         opa_o <= '0;
         opb_o <= '0;
      end
      else if (launch_i)
      begin
         opa_o <= vs1_i;
         opb_o <= opb;
      end
   end

endmodule

// ==== hdl/dpu_result_stage.sv ====
`timescale 1ns/1ps

module dpu_result_stage
  (
   input  logic                                             clk_i,
   input  logic                                             rstn_i,

   input  logic                                             res_vld_i,
   input  logic [dpu_op_pkg::SEW_W-1:0]                     sew_i,
   input  logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] res_i,

   output logic                                             done_o,
   output logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] res_o
  );

   logic [dpu_cfg_pkg::LANE_NUM-1:0][dpu_cfg_pkg::LANE_W-1:0] res_q;
   logic [dpu_cfg_pkg::LANE_W-1:0] keep_mask;

   ////////////////////////////////////////////////////////////////////////////
   // Bits covered by whole element groups

   always_comb
   begin
      int ew;
      int grp_bits;
      case (sew_i)
         dpu_op_pkg::SEW_8:  ew = 8;
         dpu_op_pkg::SEW_16: ew = 16;
         dpu_op_pkg::SEW_32: ew = 32;
         default:            ew = 0;
      endcase
      grp_bits = (ew == 0) ? 0 : (dpu_cfg_pkg::LANE_W / ew) * ew;
      for (int i = 0; i < dpu_cfg_pkg::LANE_W; i++)
      begin
         keep_mask[i] = (i < grp_bits);
      end
   end

   // Result registers, read back by the host
   always_ff @(posedge clk_i)
   begin
      if (!rstn_i)
         res_q <= '0;
      else if (res_vld_i)
      begin
         for (int l = 0; l < dpu_cfg_pkg::LANE_NUM; l++)
         begin
            res_q[l] <= res_i[l*dpu_cfg_pkg::LANE_W +: dpu_cfg_pkg::LANE_W] & keep_mask;
         end
      end
   end

   assign done_o = res_vld_i;   // Busy count drops with the write
   assign res_o  = res_q;

endmodule

// ==== hdl/dpu_top.sv ====
`timescale 1ns/1ps

module dpu_top
  (
   input  logic                          clk_i,
   input  logic                          rstn_i,

   input  logic [dpu_cfg_pkg::ADR_W-1:0] wb_adr_i,
   input  logic [31:0]                   wb_dat_i,
   input  logic                          wb_we_i,
   input  logic                          wb_cyc_i,
   input  logic                          wb_stb_i,
   output logic [31:0]                   wb_dat_o,
   output logic                          wb_ack_o
  );

   logic        launch;
   logic [31:0] ctrl;
   logic [31:0] scalar;
   logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] vs1;
   logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] vs2;

   // Between pipeline stages
   logic                            op_vld;
   logic [dpu_op_pkg::OPMODE_W-1:0] opmode;
   logic [dpu_op_pkg::SEW_W-1:0]    op_sew;
   logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] opa;
   logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] opb;
   logic                            alu_vld;
   logic [dpu_op_pkg::SEW_W-1:0]    alu_sew;
   logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] alu_res;
   logic                            done;
   logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] res;

   dpu_wb_regs regs_inst
     (
      .clk_i(clk_i), .rstn_i(rstn_i),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_we_i(wb_we_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .res_i(res), .done_i(done),
      .launch_o(launch), .ctrl_o(ctrl), .vs1_o(vs1), .vs2_o(vs2), .scalar_o(scalar)
      );

   dpu_operand_stage operand_inst
     (
      .clk_i(clk_i), .rstn_i(rstn_i),
      .launch_i(launch), .ctrl_i(ctrl), .vs1_i(vs1), .vs2_i(vs2), .scalar_i(scalar),
      .op_vld_o(op_vld), .opmode_o(opmode), .sew_o(op_sew), .opa_o(opa), .opb_o(opb)
      );

   dpu_alu_stage alu_inst
     (
      .clk_i(clk_i), .rstn_i(rstn_i),
      .op_vld_i(op_vld), .opmode_i(opmode), .sew_i(op_sew), .opa_i(opa), .opb_i(opb),
      .res_vld_o(alu_vld), .sew_o(alu_sew), .res_o(alu_res)
      );

   dpu_result_stage result_inst
     (
      .clk_i(clk_i), .rstn_i(rstn_i),
      .res_vld_i(alu_vld), .sew_i(alu_sew), .res_i(alu_res),
      .done_o(done), .res_o(res)
      );

endmodule

// ==== hdl/dpu_wb_regs.sv ====
`timescale 1ns/1ps

module dpu_wb_regs
  (
   input  logic                                             clk_i,
   input  logic                                             rstn_i,

   input  logic [dpu_cfg_pkg::ADR_W-1:0]                    wb_adr_i,
   input  logic [31:0]                                      wb_dat_i,
   input  logic                                             wb_we_i,
   input  logic                                             wb_cyc_i,
   input  logic                                             wb_stb_i,
   output logic [31:0]                                      wb_dat_o,
   output logic                                             wb_ack_o,

   input  logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] res_i,
   input  logic                                             done_i,

   output logic                                             launch_o,
   output logic [31:0]                                      ctrl_o,
   output logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] vs1_o,
   output logic [dpu_cfg_pkg::LANE_NUM*dpu_cfg_pkg::LANE_W-1:0] vs2_o,
   output logic [31:0]                                      scalar_o
  );

   logic [dpu_cfg_pkg::LANE_NUM-1:0][dpu_cfg_pkg::LANE_W-1:0] vs1_q;
   logic [dpu_cfg_pkg::LANE_NUM-1:0][dpu_cfg_pkg::LANE_W-1:0] vs2_q;
   logic [31:0] scalar_q;
   logic [31:0] ctrl_q;
   logic [1:0]  busy_cnt;   // At most two in flight
   logic        req;
   logic        wr_en;
   logic [31:0] rd_data;

   assign req   = wb_cyc_i && wb_stb_i;
   assign wr_en = req && wb_we_i && !wb_ack_o;   // Same edge as ack rises

   ////////////////////////////////////////////////////////////////////////////
   // Handshake and read data

   always_ff @(posedge clk_i)
   begin
      if (!rstn_i)
      begin
         wb_ack_o <= 1'b0;
         wb_dat_o <= '0;
      end
      else
      begin
         wb_ack_o <= req && !wb_ack_o;
         if (req && !wb_we_i && !wb_ack_o)
            wb_dat_o <= rd_data;
      end
   end

   always_comb
   begin
      rd_data = '0;
      for (int i = 0; i < dpu_cfg_pkg::LANE_NUM; i++)
      begin
         if (int'(wb_adr_i) == int'(dpu_cfg_pkg::ADR_VS1_BASE) + i)
            rd_data = vs1_q[i];
         if (int'(wb_adr_i) == int'(dpu_cfg_pkg::ADR_VS2_BASE) + i)
            rd_data = vs2_q[i];
         if (int'(wb_adr_i) == int'(dpu_cfg_pkg::ADR_RES_BASE) + i)
            rd_data = res_i[i*dpu_cfg_pkg::LANE_W +: dpu_cfg_pkg::LANE_W];
      end
      if (wb_adr_i == dpu_cfg_pkg::ADR_SCALAR)
         rd_data = scalar_q;
      if (wb_adr_i == dpu_cfg_pkg::ADR_CTRL)
         rd_data = ctrl_q;
      if (wb_adr_i == dpu_cfg_pkg::ADR_STATUS)
         rd_data[0] = (busy_cnt != 2'd0);
   end

   ////////////////////////////////////////////////////////////////////////////
   // Operand and control registers

   always_ff @(posedge clk_i)
   begin
      if (!rstn_i)
      begin
         vs1_q    <= '0;
         vs2_q    <= '0;
         scalar_q <= '0;
         ctrl_q   <= '0;
         launch_o <= 1'b0;
      end
      else
      begin
         launch_o <= wr_en && (wb_adr_i == dpu_cfg_pkg::ADR_CTRL);
         if (wr_en)
         begin
            for (int i = 0; i < dpu_cfg_pkg::LANE_NUM; i++)
            begin
               if (int'(wb_adr_i) == int'(dpu_cfg_pkg::ADR_VS1_BASE) + i)
                  vs1_q[i] <= wb_dat_i;
               if (int'(wb_adr_i) == int'(dpu_cfg_pkg::ADR_VS2_BASE) + i)
                  vs2_q[i] <= wb_dat_i;
            end
            if (wb_adr_i == dpu_cfg_pkg::ADR_SCALAR)
               scalar_q <= wb_dat_i;
            if (wb_adr_i == dpu_cfg_pkg::ADR_CTRL)
               ctrl_q <= wb_dat_i;
         end
      end
   end

   // Operations in flight
   always_ff @(posedge clk_i)
   begin
      if (!rstn_i)
         busy_cnt <= 2'd0;
      else if (launch_o && !done_i)
         busy_cnt <= busy_cnt + 2'd1;
      else if (!launch_o && done_i)
         busy_cnt <= busy_cnt - 2'd1;
   end

   assign vs1_o    = vs1_q;
   assign vs2_o    = vs2_q;
   assign scalar_o = scalar_q;
   assign ctrl_o   = ctrl_q;

endmodule
